//--- design/cu_arbiter_control.sv
// Vertex CU arbiter control
`timescale 1ns/10ps
`default_nettype none

module cu_arbiter_control #(
	parameter int NUM_VERTEX_CU           = 4,
	parameter int READ_CMD_BUFFER_DEPTH   = 16,
	parameter int VERTEX_JOB_BUFFER_DEPTH = 8
) (
	input  logic                                              clock,
	input  logic                                              rstn,
	input  logic                                              enabled_in,
	input  cu_arbiter_pkg::read_command_t [NUM_VERTEX_CU-1:0]  read_command_cu_in,
	input  logic [NUM_VERTEX_CU-1:0]                          request_read_command_cu_in,
	input  logic                                              read_buffer_alfull,
	input  logic                                              read_command_bus_grant,
	input  cu_arbiter_pkg::read_response_t                    read_response_in,
	input  cu_arbiter_pkg::vertex_job_t                       vertex_job_in,
	input  logic [NUM_VERTEX_CU-1:0]                          request_vertex_job_cu_in,
	output logic [NUM_VERTEX_CU-1:0]                          ready_read_command_cu_out,
	output cu_arbiter_pkg::read_command_t                     read_command_out,
	output logic                                              read_command_bus_request,
	output cu_arbiter_pkg::read_response_t [NUM_VERTEX_CU-1:0] read_response_cu_out,
	output logic                                              vertex_job_request,
	output cu_arbiter_pkg::vertex_job_t [NUM_VERTEX_CU-1:0]    vertex_job_cu_out
);

	logic enabled;

	////////////////////
	// Enable register
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	////////////////////
	// Paths
	////////////////////

	read_command_path #(
		.NUM_VERTEX_CU        (NUM_VERTEX_CU),
		.READ_CMD_BUFFER_DEPTH(READ_CMD_BUFFER_DEPTH)
	) read_command_path_inst (
		.clock                     (clock),
		.rstn                      (rstn),
		.enabled                   (enabled),
		.read_command_cu_in        (read_command_cu_in),
		.request_read_command_cu_in(request_read_command_cu_in),
		.read_buffer_alfull        (read_buffer_alfull),
		.read_command_bus_grant    (read_command_bus_grant),
		.ready_read_command_cu_out (ready_read_command_cu_out),
		.read_command_out          (read_command_out),
		.read_command_bus_request  (read_command_bus_request)
	);

	vertex_job_dispatch #(
		.NUM_VERTEX_CU          (NUM_VERTEX_CU),
		.VERTEX_JOB_BUFFER_DEPTH(VERTEX_JOB_BUFFER_DEPTH)
	) vertex_job_dispatch_inst (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled                 (enabled),
		.vertex_job_in           (vertex_job_in),
		.request_vertex_job_cu_in(request_vertex_job_cu_in),
		.vertex_job_request      (vertex_job_request),
		.vertex_job_cu_out       (vertex_job_cu_out)
	);

	// Responses are never held back
	response_router #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) response_router_inst (
		.clock               (clock),
		.rstn                (rstn),
		.read_response_in    (read_response_in),
		.read_response_cu_out(read_response_cu_out)
	);

endmodule

`default_nettype wire

//--- design/cu_arbiter_pkg.sv
// CU arbiter shared types
`default_nettype none

package cu_arbiter_pkg;

	// Field widths
	localparam int CU_ID_BITS     = 8;
	localparam int ADDRESS_BITS   = 32;
	localparam int VERTEX_ID_BITS = 32;
	localparam int TAG_BITS       = 8;

	typedef logic [CU_ID_BITS-1:0] cu_id_t;

	////////////////////
	// Command and response words
	////////////////////

	// Read command from a CU toward the memory port
	typedef struct packed {
		logic                    valid;
		cu_id_t                  cu_id;
		logic [ADDRESS_BITS-1:0] address;
		logic [7:0]              size;
	} read_command_t;

	// Read response routed back by cu_id
	typedef struct packed {
		logic                valid;
		cu_id_t              cu_id;
		logic [TAG_BITS-1:0] tag;
	} read_response_t;

	////////////////////
	// Vertex jobs
	////////////////////

	typedef struct packed {
		logic                      valid;
		logic [VERTEX_ID_BITS-1:0] vertex_id;
		logic [15:0]               out_degree;
	} vertex_job_t;

endpackage

`default_nettype wire

//--- design/read_command_path.sv
// Read command arbitration and burst buffer
`timescale 1ns/10ps
`default_nettype none

module read_command_path #(
	parameter int NUM_VERTEX_CU         = 4,
	parameter int READ_CMD_BUFFER_DEPTH = 16
) (
	input  logic                                             clock,
	input  logic                                             rstn,
	input  logic                                             enabled,
	input  cu_arbiter_pkg::read_command_t [NUM_VERTEX_CU-1:0] read_command_cu_in,
	input  logic [NUM_VERTEX_CU-1:0]                         request_read_command_cu_in,
	input  logic                                             read_buffer_alfull,
	input  logic                                             read_command_bus_grant,
	output logic [NUM_VERTEX_CU-1:0]                         ready_read_command_cu_out,
	output cu_arbiter_pkg::read_command_t                    read_command_out,
	output logic                                             read_command_bus_request
);

	import cu_arbiter_pkg::*;

	logic [NUM_VERTEX_CU-1:0] eligible;
	logic [NUM_VERTEX_CU-1:0] grant;
	logic                     take;
	read_command_t            selected;
	read_command_t            taken_command;
	logic                     taken_valid;
	read_command_t            buffer_head;
	logic                     buffer_empty;
	logic                     buffer_almost_full;
	logic                     buffer_pop;
	read_command_t            out_payload;
	logic                     out_valid;

	////////////////////
	// CU arbitration
	////////////////////

	// CU served last cycle sits out until it updates its request
	always_comb begin
		selected = '0;
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			eligible[i] = request_read_command_cu_in[i] && read_command_cu_in[i].valid &&
				!ready_read_command_cu_out[i];
			if (grant[i]) begin
				selected = read_command_cu_in[i];
			end
		end
	end

	assign take = enabled && !buffer_almost_full && (|eligible);

	round_robin_select #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) command_select (
		.clock   (clock),
		.rstn    (rstn),
		.requests(eligible),
		.advance (take),
		.grant   (grant)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready_read_command_cu_out <= '0;
			taken_valid               <= 1'b0;
		end else begin
			ready_read_command_cu_out <= take ? grant : '0;
			taken_valid               <= take;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			taken_command <= selected;
		end
	end

	////////////////////
	// Burst buffer
	////////////////////

	sync_fifo #(
		.WIDTH($bits(read_command_t)),
		.DEPTH(READ_CMD_BUFFER_DEPTH)
	) burst_buffer (
		.clock      (clock),
		.rstn       (rstn),
		.push       (taken_valid),
		.data_in    (taken_command),
		.pop        (buffer_pop),
		.data_out   (buffer_head),
		.empty      (buffer_empty),
		.full       (),
		.almost_full(buffer_almost_full)
	);

	// Bus side pops one entry per sampled grant
	assign buffer_pop = enabled && read_command_bus_grant && !buffer_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_bus_request <= 1'b0;
			out_valid                <= 1'b0;
		end else begin
			if (enabled) begin
				read_command_bus_request <= !buffer_empty && !read_buffer_alfull;
			end
			out_valid <= buffer_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (buffer_pop) begin
			out_payload <= buffer_head;
		end
	end

	always_comb begin
		read_command_out       = out_payload;
		read_command_out.valid = out_valid;
	end

endmodule

`default_nettype wire

//--- design/response_router.sv
// Read response demux by CU id
`timescale 1ns/10ps
`default_nettype none

module response_router #(
	parameter int NUM_VERTEX_CU = 4
) (
	input  logic                                              clock,
	input  logic                                              rstn,
	input  cu_arbiter_pkg::read_response_t                    read_response_in,
	output cu_arbiter_pkg::read_response_t [NUM_VERTEX_CU-1:0] read_response_cu_out
);

	import cu_arbiter_pkg::*;

	localparam int SEL_BITS = $clog2(NUM_VERTEX_CU);

	read_response_t           held;
	logic                     held_valid;
	logic [NUM_VERTEX_CU-1:0] decoded;
	logic [NUM_VERTEX_CU-1:0] lane_valid;
	read_response_t           lane_payload;

	// Input stage
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			held_valid <= 1'b0;
			lane_valid <= '0;
		end else begin
			held_valid <= read_response_in.valid;
			lane_valid <= decoded;
		end
	end

	always_ff @(posedge clock) begin
		held         <= read_response_in;
		lane_payload <= held;
	end

	// Low CU id bits pick the lane
	always_comb begin
		decoded = '0;
		if (held_valid) begin
			decoded[held.cu_id[SEL_BITS-1:0]] = 1'b1;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			read_response_cu_out[i]       = lane_payload;
			read_response_cu_out[i].valid = lane_valid[i];
		end
	end

endmodule

`default_nettype wire

//--- design/round_robin_select.sv
// Rotating priority grant
`timescale 1ns/10ps
`default_nettype none

module round_robin_select #(
	parameter int NUM_VERTEX_CU = 4
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic [NUM_VERTEX_CU-1:0] requests,
	input  logic                     advance,
	output logic [NUM_VERTEX_CU-1:0] grant
);

	localparam int INDEX_BITS = $clog2(NUM_VERTEX_CU);

	logic [INDEX_BITS-1:0] last_index;
	logic [INDEX_BITS-1:0] grant_index;
	logic [INDEX_BITS-1:0] candidate;
	logic                  found;

	// Search starts one past the last winner and wraps by truncation
	always_comb begin
		grant       = '0;
		grant_index = last_index;
		candidate   = last_index;
		found       = 1'b0;
		for (int offset = 1; offset <= NUM_VERTEX_CU; offset++) begin
			candidate = last_index + INDEX_BITS'(offset);
			if (!found && requests[candidate]) begin
				found       = 1'b1;
				grant_index = candidate;
			end
		end
		if (found) begin
			grant[grant_index] = 1'b1;
		end
	end

	// CU 0 has first pick out of reset
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_index <= INDEX_BITS'(NUM_VERTEX_CU - 1);
		end else if (advance) begin
			last_index <= grant_index;
		end
	end

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
// Synchronous first-word-fall-through FIFO
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty,
	output logic             full,
	output logic             almost_full
);

	localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_BITS = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]      storage [DEPTH];
	logic [PTR_BITS-1:0]   read_ptr;
	logic [PTR_BITS-1:0]   write_ptr;
	logic [COUNT_BITS-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	// Pointer step with wrap at DEPTH
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty       = (count == '0);
	assign full        = (count == COUNT_BITS'(DEPTH));
	// Two or fewer free entries
	assign almost_full = (count >= COUNT_BITS'(DEPTH - 2));
	assign data_out    = storage[read_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			storage[write_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_ptr  <= '0;
			write_ptr <= '0;
			count     <= '0;
		end else begin
			if (do_push) begin
				write_ptr <= next_ptr(write_ptr);
			end
			if (do_pop) begin
				read_ptr <= next_ptr(read_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/vertex_job_dispatch.sv
// Vertex job buffer and distribution
`timescale 1ns/10ps
`default_nettype none

module vertex_job_dispatch #(
	parameter int NUM_VERTEX_CU           = 4,
	parameter int VERTEX_JOB_BUFFER_DEPTH = 8
) (
	input  logic                                           clock,
	input  logic                                           rstn,
	input  logic                                           enabled,
	input  cu_arbiter_pkg::vertex_job_t                    vertex_job_in,
	input  logic [NUM_VERTEX_CU-1:0]                       request_vertex_job_cu_in,
	output logic                                           vertex_job_request,
	output cu_arbiter_pkg::vertex_job_t [NUM_VERTEX_CU-1:0] vertex_job_cu_out
);

	import cu_arbiter_pkg::*;

	logic [NUM_VERTEX_CU-1:0] grant;
	logic                     job_pop;
	vertex_job_t              job_head;
	logic                     job_empty;
	logic                     job_almost_full;
	logic [NUM_VERTEX_CU-1:0] lane_valid;
	vertex_job_t              lane_payload;

	////////////////////
	// Job buffer
	////////////////////

	sync_fifo #(
		.WIDTH($bits(vertex_job_t)),
		.DEPTH(VERTEX_JOB_BUFFER_DEPTH)
	) job_buffer (
		.clock      (clock),
		.rstn       (rstn),
		.push       (vertex_job_in.valid),
		.data_in    (vertex_job_in),
		.pop        (job_pop),
		.data_out   (job_head),
		.empty      (job_empty),
		.full       (),
		.almost_full(job_almost_full)
	);

	////////////////////
	// Distribution
	////////////////////

	// Head job goes out whenever someone is asking
	assign job_pop = enabled && !job_empty && (|request_vertex_job_cu_in);

	round_robin_select #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) job_select (
		.clock   (clock),
		.rstn    (rstn),
		.requests(request_vertex_job_cu_in),
		.advance (job_pop),
		.grant   (grant)
	);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_request <= 1'b0;
			lane_valid         <= '0;
		end else begin
			if (enabled) begin
				vertex_job_request <= !job_almost_full;
			end
			lane_valid <= job_pop ? grant : '0;
		end
	end

	always_ff @(posedge clock) begin
		if (job_pop) begin
			lane_payload <= job_head;
		end
	end

	// Shared payload with valid set only on the chosen lane
	always_comb begin
		for (int i = 0; i < NUM_VERTEX_CU; i++) begin
			vertex_job_cu_out[i]       = lane_payload;
			vertex_job_cu_out[i].valid = lane_valid[i];
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the CU arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f \
	--top-module cu_arbiter_control_tb -o sim_cu_arbiter
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_cu_arbiter > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

//--- tb.f
design/cu_arbiter_pkg.sv
design/sync_fifo.sv
design/round_robin_select.sv
design/read_command_path.sv
design/vertex_job_dispatch.sv
design/response_router.sv
design/cu_arbiter_control.sv
testbench/tb_clock_gen.sv
testbench/cu_arbiter_control_props.sv
testbench/cu_arbiter_control_tb.sv

//--- testbench/cu_arbiter_control_props.sv
// Read command path assertions
`timescale 1ns/10ps
`default_nettype none

module cu_arbiter_control_props #(
	parameter int NUM_VERTEX_CU = 4
) (
	input logic                          clock,
	input logic                          rstn,
	input logic                          enabled,
	input logic [NUM_VERTEX_CU-1:0]      ready_read_command_cu_out,
	input cu_arbiter_pkg::read_command_t read_command_out,
	input logic                          read_command_bus_request,
	input logic                          read_buffer_alfull,
	input logic                          read_command_bus_grant
);

	// At most one CU served per cycle
	ready_one_hot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(ready_read_command_cu_out))
		else $error("ready pulsed to more than one CU");

	// Output only follows a sampled bus grant
	output_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		$rose(read_command_out.valid) |-> $past(read_command_bus_grant))
		else $error("read command left without a bus grant");

	// Downstream buffer full blocks the bus request
	no_request_when_full: assert property (@(posedge clock) disable iff (!rstn || !enabled)
		$past(read_buffer_alfull) |-> !read_command_bus_request)
		else $error("bus request raised while read buffer almost full");

endmodule

`default_nettype wire

//--- testbench/cu_arbiter_control_tb.sv
// CU arbiter control testbench
`timescale 1ns/10ps
`default_nettype none

module cu_arbiter_control_tb;

	import cu_arbiter_pkg::*;

	localparam int NUM_CU         = 4;
	localparam int SEL_BITS       = 2;
	localparam int JOB_DEPTH      = 8;
	localparam int TIMEOUT_CYCLES = 200;

	logic                         clock;
	logic                         rstn;
	logic                         enabled_in;
	read_command_t [NUM_CU-1:0]   read_command_cu_in;
	logic [NUM_CU-1:0]            request_read_command_cu_in;
	logic                         read_buffer_alfull;
	logic                         read_command_bus_grant;
	read_response_t               read_response_in;
	vertex_job_t                  vertex_job_in;
	logic [NUM_CU-1:0]            request_vertex_job_cu_in;
	logic [NUM_CU-1:0]            ready_read_command_cu_out;
	read_command_t                read_command_out;
	logic                         read_command_bus_request;
	read_response_t [NUM_CU-1:0]  read_response_cu_out;
	logic                         vertex_job_request;
	vertex_job_t [NUM_CU-1:0]     vertex_job_cu_out;

	// Stimulus side state
	logic [31:0]   lfsr_state;
	logic          bus_active;
	string         current_test;
	int            check_errors;
	int            errors_before;
	int            tests_run;
	int            tests_failed;
	int            issued_count [NUM_CU];
	read_command_t command_table [NUM_CU];
	vertex_job_t   job_table [32];
	int            jobs_pushed;

	// Comparison side state
	int                  compare_errors;
	int                  served_count [NUM_CU];
	int                  acked_count [NUM_CU];
	logic [SEL_BITS-1:0] last_read_cu;
	logic [SEL_BITS-1:0] last_job_cu;
	int                  jobs_seen;
	logic [NUM_CU-1:0]   prev_job_requests;
	read_response_t      rsp_d1;
	read_response_t      rsp_d2;

	tb_clock_gen clock_gen (
		.clock(clock),
		.rstn (rstn)
	);

	cu_arbiter_control uut (
		.clock                     (clock),
		.rstn                      (rstn),
		.enabled_in                (enabled_in),
		.read_command_cu_in        (read_command_cu_in),
		.request_read_command_cu_in(request_read_command_cu_in),
		.read_buffer_alfull        (read_buffer_alfull),
		.read_command_bus_grant    (read_command_bus_grant),
		.read_response_in          (read_response_in),
		.vertex_job_in             (vertex_job_in),
		.request_vertex_job_cu_in  (request_vertex_job_cu_in),
		.ready_read_command_cu_out (ready_read_command_cu_out),
		.read_command_out          (read_command_out),
		.read_command_bus_request  (read_command_bus_request),
		.read_response_cu_out      (read_response_cu_out),
		.vertex_job_request        (vertex_job_request),
		.vertex_job_cu_out         (vertex_job_cu_out)
	);

	bind read_command_path cu_arbiter_control_props #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) read_props (
		.clock                    (clock),
		.rstn                     (rstn),
		.enabled                  (enabled),
		.ready_read_command_cu_out(ready_read_command_cu_out),
		.read_command_out         (read_command_out),
		.read_command_bus_request (read_command_bus_request),
		.read_buffer_alfull       (read_buffer_alfull),
		.read_command_bus_grant   (read_command_bus_grant)
	);

	////////////////////
	// Random source and reference model
	////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// Next requester after the last one served, or -1
	function automatic int next_round_robin(input logic [SEL_BITS-1:0] last,
		input logic [NUM_CU-1:0] requests);
		logic [SEL_BITS-1:0] index;
		for (int offset = 1; offset <= NUM_CU; offset++) begin
			index = SEL_BITS'((int'(last) + offset) % NUM_CU);
			if (requests[index]) begin
				return int'(index);
			end
		end
		return -1;
	endfunction

	function automatic logic [NUM_CU-1:0] expected_response_lanes(input read_response_t rsp);
		logic [NUM_CU-1:0] lanes;
		lanes = '0;
		if (rsp.valid) begin
			lanes[SEL_BITS'(rsp.cu_id % NUM_CU)] = 1'b1;
		end
		return lanes;
	endfunction

	function automatic logic [NUM_CU-1:0] pending_reads();
		logic [NUM_CU-1:0] pending;
		for (int i = 0; i < NUM_CU; i++) begin
			pending[i] = (issued_count[i] != served_count[i]);
		end
		return pending;
	endfunction

	function automatic int total_errors();
		return check_errors + compare_errors;
	endfunction

	task automatic print_mismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("Fail %s %s: expected %h, actual %h", current_test, what, expected, actual);
	endtask

	////////////////////
	// Output comparison
	////////////////////

	always @(negedge clock) begin
		logic [NUM_CU-1:0]   lanes;
		logic [NUM_CU-1:0]   actual;
		logic [SEL_BITS-1:0] lane;
		int                  pick;
		if (rstn) begin
			// Responses trail the input by two cycles
			lanes = expected_response_lanes(rsp_d2);
			for (int i = 0; i < NUM_CU; i++) begin
				actual[i] = read_response_cu_out[i].valid;
			end
			lane = SEL_BITS'(rsp_d2.cu_id % NUM_CU);
			if (actual !== lanes) begin
				print_mismatch("response lanes", 64'(lanes), 64'(actual));
				compare_errors++;
			end else if (rsp_d2.valid && read_response_cu_out[lane] !== rsp_d2) begin
				print_mismatch("response", 64'(rsp_d2), 64'(read_response_cu_out[lane]));
				compare_errors++;
			end
			rsp_d2 = rsp_d1;
			rsp_d1 = read_response_in;

			// Each ready pulse hands over one waiting command
			for (int i = 0; i < NUM_CU; i++) begin
				if (ready_read_command_cu_out[i]) begin
					if (acked_count[i] == issued_count[i]) begin
						$display("Error %s: ready pulsed to CU %0d with no command waiting",
							current_test, i);
						compare_errors++;
					end else begin
						acked_count[i]++;
					end
				end
			end

			// Bus side read commands
			if (read_command_out.valid) begin
				pick = next_round_robin(last_read_cu, pending_reads());
				if (pick < 0) begin
					$display("Error %s: read command came out with none pending", current_test);
					compare_errors++;
				end else begin
					lane = SEL_BITS'(pick);
					if (read_command_out !== command_table[lane]) begin
						print_mismatch("read command", 64'(command_table[lane]),
							64'(read_command_out));
						compare_errors++;
					end
					served_count[lane]++;
					last_read_cu = lane;
				end
			end

			// Vertex jobs
			for (int i = 0; i < NUM_CU; i++) begin
				actual[i] = vertex_job_cu_out[i].valid;
			end
			if (actual != '0) begin
				pick = next_round_robin(last_job_cu, prev_job_requests);
				if (pick < 0 || jobs_seen >= jobs_pushed) begin
					$display("Error %s: vertex job delivered without a request", current_test);
					compare_errors++;
				end else begin
					lane  = SEL_BITS'(pick);
					lanes = '0;
					lanes[lane] = 1'b1;
					if (actual !== lanes) begin
						print_mismatch("job lanes", 64'(lanes), 64'(actual));
						compare_errors++;
					end else if (vertex_job_cu_out[lane] !== job_table[jobs_seen]) begin
						print_mismatch("job", 64'(job_table[jobs_seen]),
							64'(vertex_job_cu_out[lane]));
						compare_errors++;
					end
					jobs_seen++;
					last_job_cu = lane;
				end
			end
			prev_job_requests = request_vertex_job_cu_in;
		end
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	task automatic step();
		@(posedge clock);
		request_read_command_cu_in <= request_read_command_cu_in & ~ready_read_command_cu_out;
		read_command_bus_grant     <= bus_active && read_command_bus_request;
		read_response_in           <= '0;
		vertex_job_in              <= '0;
	endtask

	task automatic start_test(input string name);
		current_test  = name;
		errors_before = total_errors();
	endtask

	task automatic finish_test();
		int errors;
		errors = total_errors() - errors_before;
		tests_run++;
		if (errors == 0) begin
			$display("Test %s: ok", current_test);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", current_test, errors);
		end
	endtask

	task automatic timed_out(input string what);
		$display("Error %s: timeout waiting for %s", current_test, what);
		check_errors++;
	endtask

	task automatic check_reset_outputs();
		logic [15:0] status;
		status = '0;
		status[0] = read_command_bus_request;
		status[1] = read_command_out.valid;
		status[2] = vertex_job_request;
		for (int i = 0; i < NUM_CU; i++) begin
			status[4 + i]  = ready_read_command_cu_out[i];
			status[8 + i]  = read_response_cu_out[i].valid;
			status[12 + i] = vertex_job_cu_out[i].valid;
		end
		if (status != '0) begin
			print_mismatch("outputs", 64'(0), 64'(status));
			check_errors++;
		end
	endtask

	// One command per CU with all CUs requesting together
	task automatic issue_read_commands();
		read_command_t [NUM_CU-1:0] commands;
		for (int i = 0; i < NUM_CU; i++) begin
			commands[i].valid   = 1'b1;
			commands[i].cu_id   = CU_ID_BITS'(i);
			commands[i].address = random_bits(ADDRESS_BITS);
			commands[i].size    = 8'(random_bits(8));
			command_table[i]    = commands[i];
			issued_count[i]++;
		end
		read_command_cu_in         <= commands;
		request_read_command_cu_in <= '1;
	endtask

	task automatic wait_reads_served();
		int cycles;
		cycles = 0;
		while (pending_reads() != '0 && cycles < TIMEOUT_CYCLES) begin
			step();
			cycles++;
		end
		if (pending_reads() != '0) begin
			timed_out("read commands");
		end
	endtask

	task automatic push_job();
		vertex_job_t job;
		job.valid      = 1'b1;
		job.vertex_id  = random_bits(VERTEX_ID_BITS);
		job.out_degree = 16'(random_bits(16));
		job_table[jobs_pushed] = job;
		jobs_pushed++;
		vertex_job_in <= job;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		read_response_t rsp;
		int             cycles;
		enabled_in                 = 1'b1;
		read_command_cu_in         = '0;
		request_read_command_cu_in = '0;
		read_buffer_alfull         = 1'b0;
		read_command_bus_grant     = 1'b0;
		read_response_in           = '0;
		vertex_job_in              = '0;
		request_vertex_job_cu_in   = '0;
		lfsr_state        = 32'hc8f2492b;
		bus_active        = 1'b0;
		check_errors      = 0;
		compare_errors    = 0;
		tests_run         = 0;
		tests_failed      = 0;
		jobs_pushed       = 0;
		jobs_seen         = 0;
		last_read_cu      = SEL_BITS'(NUM_CU - 1);
		last_job_cu       = SEL_BITS'(NUM_CU - 1);
		prev_job_requests = '0;
		rsp_d1            = '0;
		rsp_d2            = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			issued_count[i] = 0;
			served_count[i] = 0;
			acked_count[i]  = 0;
			command_table[i] = '0;
		end

		start_test("reset");
		cycles = 0;
		@(negedge clock);
		while (rstn !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
			check_reset_outputs();
			@(negedge clock);
			cycles++;
		end
		if (rstn !== 1'b1) begin
			timed_out("reset release");
		end
		// First cycle after release
		check_reset_outputs();
		finish_test();

		start_test("response_routing");
		for (int n = 0; n < 20; n++) begin
			step();
			rsp.valid = 1'b1;
			rsp.cu_id = CU_ID_BITS'(random_bits(CU_ID_BITS));
			rsp.tag   = TAG_BITS'(random_bits(TAG_BITS));
			read_response_in <= rsp;
		end
		repeat (4) step();
		finish_test();

		start_test("read_arbitration");
		bus_active = 1'b1;
		step();
		issue_read_commands();
		wait_reads_served();
		repeat (3) step();
		finish_test();

		start_test("bus_backpressure");
		step();
		read_buffer_alfull <= 1'b1;
		step();
		step();
		issue_read_commands();
		for (int n = 0; n < 12; n++) begin
			step();
			@(negedge clock);
			if (read_command_bus_request || read_command_out.valid) begin
				print_mismatch("request and valid", 64'(0),
					64'({read_command_bus_request, read_command_out.valid}));
				check_errors++;
			end
		end
		step();
		read_buffer_alfull <= 1'b0;
		wait_reads_served();
		repeat (3) step();
		finish_test();

		start_test("job_distribution");
		bus_active = 1'b0;
		step();
		request_vertex_job_cu_in <= 4'b0110;
		for (int n = 0; n < 8; n++) begin
			step();
			push_job();
		end
		cycles = 0;
		while (jobs_seen != jobs_pushed && cycles < TIMEOUT_CYCLES) begin
			step();
			cycles++;
		end
		if (jobs_seen != jobs_pushed) begin
			timed_out("vertex jobs");
		end
		step();
		request_vertex_job_cu_in <= '0;
		step();
		finish_test();

		start_test("job_almost_full");
		for (int n = 0; n < JOB_DEPTH - 2; n++) begin
			step();
			push_job();
			repeat (3) step();
			@(negedge clock);
			if (vertex_job_request !== (n + 1 < JOB_DEPTH - 2)) begin
				print_mismatch("job request", 64'(n + 1 < JOB_DEPTH - 2),
					64'(vertex_job_request));
				check_errors++;
			end
		end
		// One job taken by CU 0
		step();
		request_vertex_job_cu_in <= 4'b0001;
		step();
		request_vertex_job_cu_in <= '0;
		cycles = 0;
		while (!vertex_job_request && cycles < TIMEOUT_CYCLES) begin
			step();
			cycles++;
		end
		if (!vertex_job_request) begin
			timed_out("job request to rise");
		end
		repeat (3) step();
		finish_test();

		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, total_errors());
		if (tests_failed == 0 && total_errors() == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Overall limit on the run
	initial begin
		repeat (20000) @(posedge clock);
		$display("Watchdog expired before the test sequence ended");
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 5,
	parameter int RESET_CYCLES   = 5
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD_NS) clock = ~clock;
	end

	// Release on a rising edge after the reset cycles
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire
